// File: common/quant_pkg.sv
package quant_pkg;

    // ********************************************************************
    // data-path widths
    // ********************************************************************

    parameter int COEF_W    = 16;   // coefficient and level width
    parameter int MAG_W     = 16;   // unsigned magnitude, holds |-32768|
    parameter int PROD_W    = 31;   // magnitude times scale
    parameter int SUM_W     = 32;   // product plus rounding offset

    // lane count used when the top level is not overridden
    parameter int LANES_DEF = 32;

    // ********************************************************************
    // opcodes
    // ********************************************************************

    typedef enum logic [0:0] {
        MODE_FWD = 1'b0,    // quantize
        MODE_INV = 1'b1     // dequantize
    } mode_e;

endpackage

// File: common/scale_pkg.sv
package scale_pkg;

    // ********************************************************************
    // scale-path widths
    // ********************************************************************

    parameter int QP_W     = 6;     // qp 0..51
    parameter int Q_W      = 16;    // multiplier width
    parameter int SHIFT_W  = 5;     // right shift amount
    parameter int OFFSET_W = 28;    // rounding offset width

    // ********************************************************************
    // transform size and slice type
    // ********************************************************************

    // coded as log2(N) - 2
    typedef enum logic [1:0] {
        SIZE_4  = 2'd0,
        SIZE_8  = 2'd1,
        SIZE_16 = 2'd2,
        SIZE_32 = 2'd3
    } size_e;

    typedef enum logic [0:0] {
        SLICE_INTER = 1'b0,
        SLICE_INTRA = 1'b1
    } slice_e;

    // ********************************************************************
    // scale tables, indexed by qp mod 6
    // ********************************************************************

    // forward quantizer multipliers
    parameter logic [Q_W-1:0] FWD_SCALE [6] = '{
        16'd26214, 16'd23302, 16'd20560,
        16'd18396, 16'd16384, 16'd14564
    };

    // inverse multipliers, scaled up by qp div 6 in the generator
    parameter logic [Q_W-1:0] INV_SCALE [6] = '{
        16'd40, 16'd45, 16'd51,
        16'd57, 16'd64, 16'd72
    };

endpackage

// File: hw/quant_scale_gen.sv
`timescale 1ns/100ps

module quant_scale_gen #(
    parameter int BIT_DEPTH = 8
) (
    input  logic                            clk,
    input  logic                            rst,
    input  quant_pkg::mode_e                i_mode,
    input  scale_pkg::size_e                i_size,
    input  scale_pkg::slice_e               i_slice,
    input  logic [scale_pkg::QP_W-1:0]      i_qp,
    output logic [scale_pkg::Q_W-1:0]       o_scale,
    output logic [scale_pkg::OFFSET_W-1:0]  o_offset,
    output logic [scale_pkg::SHIFT_W-1:0]   o_shift
);

    import quant_pkg::*;
    import scale_pkg::*;

    // ********************************************************************
    // rounding constants
    // ********************************************************************

    localparam int FWD_SHIFT_BASE  = 29;   // 14 + 15 for the forward path
    localparam int FWD_OFS_POS     = 9;    // round factors are in 1/512 units
    localparam int FWD_ROUND_INTRA = 171;  // about 1/3
    localparam int FWD_ROUND_INTER = 85;   // about 1/6
    localparam int INV_SHIFT_BASE  = 5;

    logic [QP_W-3:0]     qp_div;    // qp / 6, up to 10
    logic [2:0]          qp_rem;    // qp % 6
    logic [2:0]          log2n;     // 2..5
    logic [OFFSET_W-1:0] fwd_round;
    logic [SHIFT_W-1:0]  shift_d;
    logic [OFFSET_W-1:0] offset_d;

    assign qp_div = (QP_W-2)'(i_qp / 6);
    assign qp_rem = 3'(i_qp % 6);
    assign log2n  = {1'b0, i_size} + 3'd2;

    assign fwd_round = (i_slice == SLICE_INTRA) ? OFFSET_W'(FWD_ROUND_INTRA)
                                                : OFFSET_W'(FWD_ROUND_INTER);

    // ********************************************************************
    // scale, shift and offset for the row now at the input
    // ********************************************************************

    always_comb begin
        if (i_mode == MODE_FWD) begin
            o_scale  = FWD_SCALE[qp_rem];
            shift_d  = SHIFT_W'(FWD_SHIFT_BASE - BIT_DEPTH + qp_div - log2n);
            offset_d = fwd_round << (shift_d - SHIFT_W'(FWD_OFS_POS));
        end else begin
            o_scale  = INV_SCALE[qp_rem] << qp_div;   // level scale times 2^(qp/6)
            shift_d  = SHIFT_W'(BIT_DEPTH + log2n - INV_SHIFT_BASE);
            offset_d = OFFSET_W'(1) << (shift_d - 1'b1);  // half of one step
        end
    end

    // offset and shift meet the product one stage later
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            o_offset <= '0;
            o_shift  <= '0;
        end else begin
            o_offset <= offset_d;
            o_shift  <= shift_d;
        end
    end

endmodule

// File: quant_lane/quant_mult_stage.sv
`timescale 1ns/100ps

module quant_mult_stage (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                i_valid,
    input  logic signed [quant_pkg::COEF_W-1:0] i_coef,
    input  logic [scale_pkg::Q_W-1:0]           i_scale,
    output logic [quant_pkg::PROD_W-1:0]        o_prod,
    output logic                                o_neg
);

    import quant_pkg::*;
    import scale_pkg::*;

    logic [MAG_W-1:0]     coef_mag;
    logic [MAG_W+Q_W-1:0] prod_full;
    logic                 coef_neg;

    // ********************************************************************
    // magnitude and multiply
    // ********************************************************************

    assign coef_neg = i_coef[COEF_W-1];

    // -32768 maps to 32768, which still fits MAG_W unsigned
    assign coef_mag = coef_neg ? (~i_coef + 1'b1) : i_coef;

    // both tables stay below 2^15, so the top bit is always clear
    assign prod_full = coef_mag * i_scale;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            o_prod <= '0;
            o_neg  <= 1'b0;
        end else if (i_valid) begin
            o_prod <= prod_full[PROD_W-1:0];
            o_neg  <= coef_neg;
        end else begin
            o_prod <= '0;       // idle rows carry zero
            o_neg  <= 1'b0;
        end
    end

endmodule

// File: quant_lane/quant_round_stage.sv
`timescale 1ns/100ps

module quant_round_stage (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                i_valid,
    input  logic [quant_pkg::PROD_W-1:0]        i_prod,
    input  logic                                i_neg,
    input  logic [scale_pkg::OFFSET_W-1:0]      i_offset,
    input  logic [scale_pkg::SHIFT_W-1:0]       i_shift,
    output logic signed [quant_pkg::COEF_W-1:0] o_level
);

    import quant_pkg::*;

    // ********************************************************************
    // saturation limits as magnitudes
    // ********************************************************************

    localparam logic [SUM_W-1:0] POS_LIM = SUM_W'((1 << (COEF_W-1)) - 1);  // 32767
    localparam logic [SUM_W-1:0] NEG_LIM = SUM_W'(1 << (COEF_W-1));        // 32768

    localparam logic [COEF_W-1:0] LEVEL_MAX = {1'b0, {(COEF_W-1){1'b1}}};
    localparam logic [COEF_W-1:0] LEVEL_MIN = {1'b1, {(COEF_W-1){1'b0}}};

    logic [SUM_W-1:0]  sum;
    logic [SUM_W-1:0]  mag;
    logic [SUM_W-1:0]  neg_mag;
    logic [COEF_W-1:0] level_d;

    assign sum     = SUM_W'(i_prod) + SUM_W'(i_offset);
    assign mag     = sum >> i_shift;
    assign neg_mag = '0 - mag;

    // sign back on, then clamp to the 16-bit range
    always_comb begin
        if (i_neg) begin
            if (mag > NEG_LIM) begin
                level_d = LEVEL_MIN;
            end else begin
                level_d = neg_mag[COEF_W-1:0];     // zero magnitude stays zero
            end
        end else begin
            if (mag > POS_LIM) begin
                level_d = LEVEL_MAX;
            end else begin
                level_d = mag[COEF_W-1:0];
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            o_level <= '0;
        end else if (i_valid) begin
            o_level <= level_d;
        end else begin
            o_level <= '0;      // output is zero between rows
        end
    end

endmodule

// File: hw/quant_top.sv
`timescale 1ns/100ps

module quant_top #(
    parameter int BIT_DEPTH = 8,
    parameter int LANES     = quant_pkg::LANES_DEF
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                i_valid,
    input  quant_pkg::mode_e                    i_mode,
    input  scale_pkg::size_e                    i_size,
    input  scale_pkg::slice_e                   i_slice,
    input  logic [scale_pkg::QP_W-1:0]          i_qp,
    input  logic signed [quant_pkg::COEF_W-1:0] i_coef [LANES],
    output logic                                o_valid,
    output logic signed [quant_pkg::COEF_W-1:0] o_level [LANES]
);

    import quant_pkg::*;
    import scale_pkg::*;

    // ********************************************************************
    // shared scale path
    // ********************************************************************

    logic [Q_W-1:0]      scale;     // same cycle as i_coef
    logic [OFFSET_W-1:0] offset;    // one cycle later
    logic [SHIFT_W-1:0]  shift;     // one cycle later
    logic                valid_s1;

    quant_scale_gen #(
        .BIT_DEPTH (BIT_DEPTH)
    ) u_scale_gen (
        .clk      (clk),
        .rst      (rst),
        .i_mode   (i_mode),
        .i_size   (i_size),
        .i_slice  (i_slice),
        .i_qp     (i_qp),
        .o_scale  (scale),
        .o_offset (offset),
        .o_shift  (shift)
    );

    // ********************************************************************
    // valid pipeline, two stages
    // ********************************************************************

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_s1 <= 1'b0;
            o_valid  <= 1'b0;
        end else begin
            valid_s1 <= i_valid;
            o_valid  <= valid_s1;
        end
    end

    // ********************************************************************
    // lane pipelines
    // ********************************************************************

    logic [PROD_W-1:0] prod [LANES];
    logic              neg  [LANES];

    for (genvar lane = 0; lane < LANES; lane++) begin : g_lane
        quant_mult_stage u_mult (
            .clk     (clk),
            .rst     (rst),
            .i_valid (i_valid),
            .i_coef  (i_coef[lane]),
            .i_scale (scale),
            .o_prod  (prod[lane]),
            .o_neg   (neg[lane])
        );

        // second stage runs on the stage-one valid
        quant_round_stage u_round (
            .clk      (clk),
            .rst      (rst),
            .i_valid  (valid_s1),
            .i_prod   (prod[lane]),
            .i_neg    (neg[lane]),
            .i_offset (offset),
            .i_shift  (shift),
            .o_level  (o_level[lane])
        );
    end

endmodule

// File: test/quant_assertions.sv
`timescale 1ns/100ps

module quant_assertions #(
    parameter int BIT_DEPTH = 8,
    parameter int LANES     = quant_pkg::LANES_DEF
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                i_valid,
    input  quant_pkg::mode_e                    i_mode,
    input  scale_pkg::size_e                    i_size,
    input  scale_pkg::slice_e                   i_slice,
    input  logic [scale_pkg::QP_W-1:0]          i_qp,
    input  logic signed [quant_pkg::COEF_W-1:0] i_coef [LANES],
    input  logic                                i_dut_valid,
    input  logic signed [quant_pkg::COEF_W-1:0] i_dut_level [LANES]
);

    import quant_pkg::*;
    import scale_pkg::*;

    // ********************************************************************
    // reference model of one lane
    // ********************************************************************

    localparam int     FWD_TBL [6] = '{26214, 23302, 20560, 18396, 16384, 14564};
    localparam int     INV_TBL [6] = '{40, 45, 51, 57, 64, 72};
    localparam longint LEVEL_MAX   = 32767;
    localparam longint LEVEL_MIN   = -32768;

    function automatic logic signed [COEF_W-1:0] expected_level(
        input logic inv,
        input int   size_code,
        input logic intra,
        input int   qp,
        input int   coef
    );
        int     log2n;
        int     shift;
        longint scale;
        longint offset;
        longint mag;
        longint res;
        log2n = size_code + 2;
        if (!inv) begin
            scale  = FWD_TBL[qp % 6];
            shift  = 29 - BIT_DEPTH + qp / 6 - log2n;
            offset = longint'(intra ? 171 : 85) << (shift - 9);
        end else begin
            scale  = longint'(INV_TBL[qp % 6]) << (qp / 6);
            shift  = BIT_DEPTH + log2n - 5;
            offset = longint'(1) << (shift - 1);    // round half up
        end
        mag = (coef < 0) ? -coef : coef;
        res = (mag * scale + offset) >> shift;
        if (coef < 0) begin
            res = -res;
        end
        if (res > LEVEL_MAX) begin
            res = LEVEL_MAX;
        end else if (res < LEVEL_MIN) begin
            res = LEVEL_MIN;
        end
        return COEF_W'(res);
    endfunction

    // expected rows travel two cycles like the DUT
    logic signed [COEF_W-1:0] exp_q1 [LANES];
    logic signed [COEF_W-1:0] exp_q2 [LANES];
    logic                     vld_q1;
    logic                     vld_q2;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            vld_q1 <= 1'b0;
            vld_q2 <= 1'b0;
            for (int l = 0; l < LANES; l++) begin
                exp_q1[l] <= '0;
                exp_q2[l] <= '0;
            end
        end else begin
            vld_q1 <= i_valid;
            vld_q2 <= vld_q1;
            for (int l = 0; l < LANES; l++) begin
                exp_q1[l] <= i_valid ? expected_level(i_mode == MODE_INV, int'(i_size),
                                                      i_slice == SLICE_INTRA, int'(i_qp),
                                                      int'(i_coef[l]))
                                     : '0;
                exp_q2[l] <= exp_q1[l];
            end
        end
    end

    // ********************************************************************
    // output checks
    // ********************************************************************

    a_valid_delay: assert property (@(posedge clk) disable iff (!rst)
        i_dut_valid == vld_q2)
    else begin
        $error("Mismatch at %0t: o_valid is %b, expected %b",
               $time, $sampled(i_dut_valid), $sampled(vld_q2));
        -> tb_quant.fail_ev;
    end

    // one edge with reset held must leave o_valid low
    a_reset_quiet: assert property (@(posedge clk) !rst |=> !i_dut_valid)
    else begin
        $error("o_valid was high at %0t after a clock edge with reset held", $time);
        -> tb_quant.fail_ev;
    end

    for (genvar l = 0; l < LANES; l++) begin : g_chk
        a_level: assert property (@(posedge clk) disable iff (!rst)
            i_dut_valid |-> i_dut_level[l] == exp_q2[l])
        else begin
            $error("Mismatch at %0t: o_level[%0d] is %0d, expected %0d",
                   $time, l, $sampled(i_dut_level[l]), $sampled(exp_q2[l]));
            -> tb_quant.fail_ev;
        end

        // also holds while reset is low
        a_idle_zero: assert property (@(posedge clk)
            !i_dut_valid |-> i_dut_level[l] == '0)
        else begin
            $error("Mismatch at %0t: o_level[%0d] is %0d, expected 0 while idle",
                   $time, l, $sampled(i_dut_level[l]));
            -> tb_quant.fail_ev;
        end
    end

endmodule

// File: test/tb_quant.sv
`timescale 1ns/100ps

module tb_quant;

    import quant_pkg::*;
    import scale_pkg::*;

    localparam int LANES          = LANES_DEF;
    localparam int FWD_ROWS       = 200;
    localparam int INV_ROWS       = 60;
    localparam int MIX_ROWS       = 60;
    localparam int TIMEOUT_CYCLES = 600;   // roughly 370 cycles of stimulus plus margin

    logic                     clk;
    logic                     rst;
    logic                     i_valid;
    mode_e                    i_mode;
    size_e                    i_size;
    slice_e                   i_slice;
    logic [QP_W-1:0]          i_qp;
    logic signed [COEF_W-1:0] i_coef [LANES];
    logic                     o_valid;
    logic signed [COEF_W-1:0] o_level [LANES];

    logic signed [COEF_W-1:0] next_coef [LANES];   // row staged for the next edge
    event                     fail_ev;
    int                       cycle_count;

    quant_top UUT (
        .clk     (clk),
        .rst     (rst),
        .i_valid (i_valid),
        .i_mode  (i_mode),
        .i_size  (i_size),
        .i_slice (i_slice),
        .i_qp    (i_qp),
        .i_coef  (i_coef),
        .o_valid (o_valid),
        .o_level (o_level)
    );

    bind quant_top quant_assertions #(
        .BIT_DEPTH (BIT_DEPTH),
        .LANES     (LANES)
    ) u_assertions (
        .clk         (clk),
        .rst         (rst),
        .i_valid     (i_valid),
        .i_mode      (i_mode),
        .i_size      (i_size),
        .i_slice     (i_slice),
        .i_qp        (i_qp),
        .i_coef      (i_coef),
        .i_dut_valid (o_valid),
        .i_dut_level (o_level)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // ********************************************************************
    // stimulus helpers
    // ********************************************************************

    function automatic logic signed [COEF_W-1:0] random_coef();
        int pick;
        pick = $urandom_range(0, 7);
        case (pick)
            0:       return 16'sh8000;     // most negative
            1:       return '0;
            2:       return 16'sh7fff;     // most positive
            3:       return COEF_W'(int'($urandom_range(0, 127)) - 64);
            default: return COEF_W'($urandom);
        endcase
    endfunction

    task automatic fill_random_row();
        for (int l = 0; l < LANES; l++) begin
            next_coef[l] = random_coef();
        end
    endtask

    // large values that drive the inverse path into saturation
    task automatic fill_directed_row(input int variant);
        for (int l = 0; l < LANES; l++) begin
            case ((l + variant) % 8)
                0:       next_coef[l] = 16'sh7fff;
                1:       next_coef[l] = 16'sh8000;
                2:       next_coef[l] = -16'sd32767;
                3:       next_coef[l] = 16'sd30000;
                4:       next_coef[l] = -16'sd30000;
                5:       next_coef[l] = 16'sd1;
                6:       next_coef[l] = -16'sd1;
                default: next_coef[l] = '0;
            endcase
        end
    endtask

    task automatic drive_row(input logic valid, input mode_e mode, input size_e size,
                             input slice_e slice, input int qp);
        @(posedge clk);
        i_valid <= valid;
        i_mode  <= mode;
        i_size  <= size;
        i_slice <= slice;
        i_qp    <= QP_W'(qp);
        for (int l = 0; l < LANES; l++) begin
            i_coef[l] <= next_coef[l];
        end
    endtask

    // idle rows carry random data that must be ignored
    task automatic idle_cycles(input int n);
        for (int k = 0; k < n; k++) begin
            fill_random_row();
            drive_row(1'b0, mode_e'($urandom_range(0, 1)), size_e'($urandom_range(0, 3)),
                      slice_e'($urandom_range(0, 1)), $urandom_range(0, 51));
        end
    endtask

    task automatic random_rows(input int n, input mode_e mode);
        for (int k = 0; k < n; k++) begin
            if ($urandom_range(0, 7) == 0) begin
                idle_cycles(1);
            end
            fill_random_row();
            drive_row(1'b1, mode, size_e'($urandom_range(0, 3)),
                      slice_e'($urandom_range(0, 1)), $urandom_range(0, 51));
        end
    endtask

    task automatic wait_drain();
        idle_cycles(2);
        while (o_valid) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        @(negedge clk);                         // settle past the last checked edge
    endtask

    // ********************************************************************
    // failure handling and timeout
    // ********************************************************************

    always @(fail_ev) begin
        $display("Verification failed");
        $fatal(1, "run stopped at the first failing assertion");
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Verification failed");
            $fatal(1, "timeout");
        end
    end

    // ********************************************************************
    // test sequence
    // ********************************************************************

    initial begin
        void'($urandom(92));
        cycle_count = 0;
        rst         = 1'b0;
        i_valid     = 1'b0;
        i_mode      = MODE_FWD;
        i_size      = SIZE_4;
        i_slice     = SLICE_INTER;
        i_qp        = '0;
        for (int l = 0; l < LANES; l++) begin
            i_coef[l]    = '0;
            next_coef[l] = '0;
        end

        repeat (5) @(posedge clk);
        rst <= 1'b1;
        idle_cycles(4);                           // outputs stay quiet after reset

        random_rows(FWD_ROWS, MODE_FWD);

        // inverse saturation at the largest step
        for (int v = 0; v < 4; v++) begin
            fill_directed_row(v);
            drive_row(1'b1, MODE_INV, SIZE_4, slice_e'(v % 2), 51);
        end
        fill_directed_row(0);
        drive_row(1'b1, MODE_INV, SIZE_32, SLICE_INTRA, 0);
        random_rows(INV_ROWS, MODE_INV);

        // every setting changes on every cycle
        for (int k = 0; k < MIX_ROWS; k++) begin
            fill_random_row();
            drive_row(1'b1, mode_e'(k % 2), size_e'($urandom_range(0, 3)),
                      slice_e'($urandom_range(0, 1)), $urandom_range(0, 51));
        end

        wait_drain();

        $display("Verification passed");
        $finish;
    end

endmodule

// File: verilog.f
common/quant_pkg.sv
common/scale_pkg.sv
hw/quant_scale_gen.sv
quant_lane/quant_mult_stage.sv
quant_lane/quant_round_stage.sv
hw/quant_top.sv
test/quant_assertions.sv
test/tb_quant.sv
